// File: tb/spike_core_patterns.txt
# W <weight address hex, neuron then axon> <weight hex>
# S <spike vector hex> <learn> <credit mode: 0 prompt, 1 random hold, 2 prompt plus stray requests>
# E <expected fired mask hex, one bit per neuron>
W 00 1e
W 01 14
W 10 0f
W 11 0f
W 22 7f
W 24 0a
W 25 0a
W 26 0a
W 27 0a
W 0f 64
W 1f 64
W 2f 64
W 3f 64
S 0003 0 0
E 1
S 0003 0 0
E 3
S 00f4 1 0
E 4
S 00f0 0 0
E 4
S 0004 0 0
E 4
S 8000 0 1
E f
S 0003 0 2
E 1
S 0003 0 0
E 3

// File: src.f
src/spike_core_pkg.sv
src/syn_mem_if.sv
src/in_spike_buf.sv
src/synapse_mem.sv
src/neuron_ctrl.sv
src/spike_out_port.sv
src/spike_core_top.sv
tb/spike_core_sva.sv
tb/tb_spike_core.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_spike_core -f src.f -o sim

./obj_dir/sim | tee sim.log

if grep -qx "Test passed" sim.log; then
	echo "simulation ok"
	exit 0
else
	echo "simulation reported a failure"
	exit 1
fi

// File: tb/tb_spike_core.sv
`timescale 1ns/10ps

module tb_spike_core import spike_core_pkg::*; ();

	// wait limits in clock cycles
	localparam int DONE_LIMIT = 1000;
	localparam int SEND_LIMIT = 400;
	// window for stray ids after the expected ones
	localparam int QUIET_CYC  = 8;

	logic       clk_i = 1'b0;
	logic       rst_n_i;
	logic       start_i;
	logic       learn_i;
	spike_vec_t spike_in_i;
	logic       cfg_we_i;
	syn_addr_t  cfg_addr_i;
	weight_t    cfg_data_i;
	logic       credit_i = 1'b0;
	logic       busy_o;
	logic       done_o;
	logic       spk_valid_o;
	neuron_id_t spk_id_o;

	// ids seen on the output, in arrival order
	neuron_id_t  rx_q [$];
	// cycle at which each held credit goes back
	int          due_q [$];
	int          cyc = 0;
	int          credit_mode = 0;
	int          credits_left = OUT_CREDITS;
	int          credit_errs = 0;
	int          errors = 0;
	int          steps = 0;
	int          failed = 0;
	logic [31:0] lfsr = 32'h30a9_9039;

	always #5 clk_i = ~clk_i;

	spike_core_top DUT (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.start_i     (start_i),
		.learn_i     (learn_i),
		.spike_in_i  (spike_in_i),
		.cfg_we_i    (cfg_we_i),
		.cfg_addr_i  (cfg_addr_i),
		.cfg_data_i  (cfg_data_i),
		.credit_i    (credit_i),
		.busy_o      (busy_o),
		.done_o      (done_o),
		.spk_valid_o (spk_valid_o),
		.spk_id_o    (spk_id_o)
	);

	// one Galois shift, taps of x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// hold time of one credit, 0 to 7 cycles in random mode
	function automatic int credit_delay(input int mode);
		int d;
		d = 0;
		if (mode == 1) begin
			for (int i = 0; i < 3; i++) begin
				lfsr = lfsr_next(lfsr);
				d = (d << 1) | int'(lfsr[0]);
			end
		end
		return d;
	endfunction

	// ------------------------------------------------------------------
	// output monitor and credit return, falling edge only
	// ------------------------------------------------------------------

	always @(negedge clk_i) begin
		int pick;
		pick = -1;
		cyc = cyc + 1;
		credit_i = 1'b0;
		if (rst_n_i) begin
			if (spk_valid_o) begin
				if (credits_left == 0) begin
					credit_errs++;
					$display("credit error: id %0d was sent with no credit left", spk_id_o);
				end else begin
					credits_left--;
				end
				rx_q.push_back(spk_id_o);
				due_q.push_back(cyc + credit_delay(credit_mode));
			end
			// at most one credit pulse per cycle
			foreach (due_q[k]) begin
				if (pick < 0 && due_q[k] <= cyc) begin
					pick = k;
				end
			end
			if (pick >= 0) begin
				due_q.delete(pick);
				credit_i = 1'b1;
				credits_left++;
			end
		end
	end

	task automatic load_weight(input syn_addr_t addr, input weight_t data);
		@(negedge clk_i);
		cfg_we_i   = 1'b1;
		cfg_addr_i = addr;
		cfg_data_i = data;
		@(negedge clk_i);
		cfg_we_i   = 1'b0;
	endtask

	// one time step, then compare the sent ids with the mask
	task automatic run_step(input spike_vec_t spikes, input logic learn, input int mode,
		input fire_vec_t mask);
		neuron_id_t exp_q [$];
		fire_vec_t  got_mask;
		int         base;
		int         err0;
		int         t;
		steps++;
		err0 = errors + credit_errs;
		base = rx_q.size();
		got_mask = '0;
		// ascending id order
		for (int n = 0; n < NUM_NEURONS; n++) begin
			if (mask[n]) begin
				exp_q.push_back(neuron_id_t'(n));
			end
		end
		credit_mode = mode;
		@(negedge clk_i);
		start_i    = 1'b1;
		spike_in_i = spikes;
		learn_i    = learn;
		@(negedge clk_i);
		start_i    = 1'b0;
		spike_in_i = '0;
		learn_i    = 1'b0;
		if (!busy_o) begin
			errors++;
			$display("FAIL step %0d: busy_o expected 1, actual 0", steps);
		end
		if (mode == 2) begin
			// stray start and weight load while busy
			start_i    = 1'b1;
			spike_in_i = 16'h8000;
			cfg_we_i   = 1'b1;
			cfg_addr_i = 6'h20;
			cfg_data_i = 8'sh7f;
			@(negedge clk_i);
			start_i    = 1'b0;
			spike_in_i = '0;
			cfg_we_i   = 1'b0;
		end
		t = 0;
		while (!done_o && t < DONE_LIMIT) begin
			@(negedge clk_i);
			t++;
		end
		if (!done_o) begin
			errors++;
			$display("step %0d: done_o never pulsed within %0d cycles", steps, DONE_LIMIT);
		end else if (busy_o) begin
			errors++;
			$display("FAIL step %0d: busy_o with done_o expected 0, actual 1", steps);
		end
		t = 0;
		while (rx_q.size() - base < exp_q.size() && t < SEND_LIMIT) begin
			@(posedge clk_i);
			t++;
		end
		if (t >= SEND_LIMIT) begin
			$display("step %0d: ids still missing after %0d cycles", steps, SEND_LIMIT);
		end
		repeat (QUIET_CYC) @(posedge clk_i);
		for (int i = base; i < rx_q.size(); i++) begin
			got_mask[rx_q[i]] = 1'b1;
		end
		if (got_mask != mask) begin
			errors++;
			$display("FAIL step %0d: fired mask expected %h, actual %h", steps, mask, got_mask);
		end
		if (rx_q.size() - base != exp_q.size()) begin
			errors++;
			$display("FAIL step %0d: id count expected %0d, actual %0d", steps,
				exp_q.size(), rx_q.size() - base);
		end else begin
			foreach (exp_q[i]) begin
				if (rx_q[base + i] != exp_q[i]) begin
					errors++;
					$display("FAIL step %0d: id #%0d expected %0d, actual %0d", steps, i,
						exp_q[i], rx_q[base + i]);
				end
			end
		end
		if (errors + credit_errs == err0) begin
			$display("step %0d: ok, mask %h", steps, mask);
		end else begin
			failed++;
			$display("step %0d: %0d check(s) wrong", steps, errors + credit_errs - err0);
		end
	endtask

	// ------------------------------------------------------------------
	// pattern file driven sequence
	// ------------------------------------------------------------------

	initial begin
		int         fd;
		int         n;
		int         a;
		int         b;
		int         c;
		byte        kind;
		string      line;
		spike_vec_t st_spikes;
		logic       st_learn;
		int         st_mode;
		rst_n_i    = 1'b0;
		start_i    = 1'b0;
		learn_i    = 1'b0;
		spike_in_i = '0;
		cfg_we_i   = 1'b0;
		cfg_addr_i = '0;
		cfg_data_i = '0;
		st_spikes  = '0;
		st_learn   = 1'b0;
		st_mode    = 0;
		repeat (16) @(negedge clk_i);
		rst_n_i = 1'b1;
		fd = $fopen("tb/spike_core_patterns.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open tb/spike_core_patterns.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != "#") begin
					kind = line.getc(0);
					a = 0;
					b = 0;
					c = 0;
					n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
					case (kind)
						"W": load_weight(syn_addr_t'(a), weight_t'(b));
						"S": begin
							st_spikes = spike_vec_t'(a);
							st_learn  = (b != 0);
							st_mode   = c;
						end
						"E": run_step(st_spikes, st_learn, st_mode, fire_vec_t'(a));
						default: ;
					endcase
				end
			end
			$fclose(fd);
		end
		errors = errors + credit_errs;
		$display("%0d steps run, %0d failed, %0d errors", steps, failed, errors);
		if (errors == 0 && steps > 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: tb/spike_core_sva.sv
`timescale 1ns/10ps

module spike_core_sva import spike_core_pkg::*; (
	input logic       clk_i,
	input logic       rst_n_i,
	input logic       start_i,
	input logic       busy_o,
	input logic       done_o,
	input logic       credit_i,
	input logic       spk_valid_o,
	// recall spike copy inside the buffer
	input spike_vec_t rcl_buf_q
);

	// sender credits as seen on the top level pins
	int crd_model;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			crd_model <= OUT_CREDITS;
		end else if (spk_valid_o && !credit_i) begin
			crd_model <= crd_model - 1;
		end else if (credit_i && !spk_valid_o && crd_model < OUT_CREDITS) begin
			crd_model <= crd_model + 1;
		end
	end

	// no send without a credit in hand
	a_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(crd_model <= 0) |-> !spk_valid_o)
		else $error("spk_valid_o high with zero credits");

	// start while busy leaves the latched spikes alone
	a_busy_start: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(start_i && busy_o) |=> $stable(rcl_buf_q))
		else $error("start_i while busy_o changed the recall spikes");

	// single cycle done, busy already low
	a_done_len: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		done_o |=> !done_o)
		else $error("done_o longer than one cycle");

	a_done_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		done_o |-> !busy_o)
		else $error("busy_o still high with done_o");

endmodule

bind spike_core_top spike_core_sva u_sva (
	.clk_i       (clk_i),
	.rst_n_i     (rst_n_i),
	.start_i     (start_i),
	.busy_o      (busy_o),
	.done_o      (done_o),
	.credit_i    (credit_i),
	.spk_valid_o (spk_valid_o),
	.rcl_buf_q   (u_buf.rcl_buf_q)
);

// File: src/spike_core_top.sv
`timescale 1ns/10ps

module spike_core_top import spike_core_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_n_i,
	// step control
	input  logic       start_i,
	input  logic       learn_i,
	input  spike_vec_t spike_in_i,
	// weight load
	input  logic       cfg_we_i,
	input  syn_addr_t  cfg_addr_i,
	input  weight_t    cfg_data_i,
	// spike output with credits
	input  logic       credit_i,
	output logic       busy_o,
	output logic       done_o,
	output logic       spk_valid_o,
	output neuron_id_t spk_id_o
);

	// host requests only count while idle
	logic start_ok;
	logic cfg_ok;
	logic rcl_rd_en;
	axon_addr_t rcl_axon;
	logic rcl_spike;
	logic save;
	logic lrn_rd_en;
	axon_addr_t lrn_axon;
	logic lrn_spike;
	logic push;
	neuron_id_t push_id;
	logic not_full;

	assign start_ok = start_i && !busy_o;
	assign cfg_ok   = cfg_we_i && !busy_o;

	syn_mem_if u_syn_if ();

	// ------------------------------------------------------------------
	// core blocks
	// ------------------------------------------------------------------

	in_spike_buf u_buf (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.start_i     (start_ok),
		.spike_in_i  (spike_in_i),
		.rcl_rd_en_i (rcl_rd_en),
		.rcl_axon_i  (rcl_axon),
		.save_i      (save),
		.lrn_rd_en_i (lrn_rd_en),
		.lrn_axon_i  (lrn_axon),
		.rcl_spike_o (rcl_spike),
		.lrn_spike_o (lrn_spike)
	);

	synapse_mem u_mem (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.cfg_we_i   (cfg_ok),
		.cfg_addr_i (cfg_addr_i),
		.cfg_data_i (cfg_data_i),
		.mem        (u_syn_if.mem)
	);

	neuron_ctrl u_ctrl (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.start_i     (start_ok),
		.learn_i     (learn_i),
		.mem         (u_syn_if.ctrl),
		.rcl_rd_en_o (rcl_rd_en),
		.rcl_axon_o  (rcl_axon),
		.rcl_spike_i (rcl_spike),
		.save_o      (save),
		.lrn_rd_en_o (lrn_rd_en),
		.lrn_axon_o  (lrn_axon),
		.lrn_spike_i (lrn_spike),
		.push_o      (push),
		.push_id_o   (push_id),
		.not_full_i  (not_full),
		.busy_o      (busy_o),
		.done_o      (done_o)
	);

	// keeps sending after the step ends
	spike_out_port u_out (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.push_i      (push),
		.push_id_i   (push_id),
		.not_full_o  (not_full),
		.credit_i    (credit_i),
		.spk_valid_o (spk_valid_o),
		.spk_id_o    (spk_id_o)
	);

endmodule

// File: src/spike_out_port.sv
`timescale 1ns/10ps

module spike_out_port import spike_core_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_n_i,
	// fired ids from the controller
	input  logic       push_i,
	input  neuron_id_t push_id_i,
	output logic       not_full_o,
	// one pulse returns one credit
	input  logic       credit_i,
	output logic       spk_valid_o,
	output neuron_id_t spk_id_o
);

	localparam int PTR_W = $clog2(OUT_DEPTH);
	localparam int CRD_W = $clog2(OUT_CREDITS + 1);

	neuron_id_t queue_q [OUT_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [PTR_W:0] count_q;
	logic [CRD_W-1:0] credit_q;
	logic do_push;
	logic do_send;

	assign not_full_o = (count_q != (PTR_W+1)'(OUT_DEPTH));
	assign do_push    = push_i && not_full_o;
	// head leaves when there is something and a credit to spend
	assign do_send    = (count_q != '0) && (credit_q != '0);

	assign spk_valid_o = do_send;
	assign spk_id_o    = queue_q[rd_ptr_q];

	// entry storage
	always_ff @(posedge clk_i) begin
		if (do_push) begin
			queue_q[wr_ptr_q] <= push_id_i;
		end
	end

	// ------------------------------------------------------------------
	// pointers, fill level, credits
	// ------------------------------------------------------------------

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			credit_q <= CRD_W'(OUT_CREDITS);
		end else begin
			if (do_push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (do_send) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			count_q <= count_q + do_push - do_send;
			// returned credit beyond the pool is dropped
			if (do_send && !credit_i) begin
				credit_q <= credit_q - 1'b1;
			end else if (credit_i && !do_send && (credit_q != CRD_W'(OUT_CREDITS))) begin
				credit_q <= credit_q + 1'b1;
			end
		end
	end

endmodule

// File: src/neuron_ctrl.sv
`timescale 1ns/10ps

module neuron_ctrl import spike_core_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_n_i,
	input  logic       start_i,
	input  logic       learn_i,
	// weight memory
	syn_mem_if.ctrl    mem,
	// spike buffer
	output logic       rcl_rd_en_o,
	output axon_addr_t rcl_axon_o,
	input  logic       rcl_spike_i,
	output logic       save_o,
	output logic       lrn_rd_en_o,
	output axon_addr_t lrn_axon_o,
	input  logic       lrn_spike_i,
	// output queue
	output logic       push_o,
	output neuron_id_t push_id_o,
	input  logic       not_full_i,
	// step status
	output logic       busy_o,
	output logic       done_o
);

	ctrl_state_t state_q;
	// walk counters, axon has one extra slot for the last data beat
	neuron_id_t nrn_q;
	logic [AXON_W:0] axn_q;
	// membrane potentials, kept across steps
	potential_t pot_q [NUM_NEURONS];
	fire_vec_t fire_q;
	logic learn_q;
	// weight read issued last cycle
	logic rd_vld_q;
	// ids handed to the queue this step
	logic [NEURON_W:0] push_cnt_q;

	potential_t leak_pot;
	logic fire_now;
	logic fire_go;
	logic walk_end;
	logic last_nrn;
	logic need_wr;
	axon_addr_t axn_rd;
	axon_addr_t axn_wr;

	// clamped add, no wrap of the potential
	function automatic potential_t sat_add(input potential_t a, input potential_t b);
		logic signed [$bits(potential_t):0] sum;
		sum = a + b;
		if (sum > POT_MAX) begin
			return POT_MAX;
		end else if (sum < POT_MIN) begin
			return POT_MIN;
		end
		return potential_t'(sum);
	endfunction

	// ------------------------------------------------------------------
	// datapath decisions
	// ------------------------------------------------------------------

	assign axn_rd   = axon_addr_t'(axn_q);
	// data in hand belongs to the previous axon
	assign axn_wr   = axon_addr_t'(axn_q - 1'b1);
	assign walk_end = axn_q[AXON_W];
	assign last_nrn = (nrn_q == neuron_id_t'(NUM_NEURONS - 1));

	// leak then threshold
	assign leak_pot = sat_add(pot_q[nrn_q], -LEAK);
	assign fire_now = (leak_pot >= THRESHOLD);
	// full queue holds a firing neuron
	assign fire_go  = (state_q == FIRE) && (!fire_now || not_full_i);

	// potentiation only for active axon into fired neuron
	assign need_wr  = (state_q == LEARN) && rd_vld_q && fire_q[nrn_q] && lrn_spike_i;

	// read requests, learning read pauses during a write
	assign rcl_rd_en_o = (state_q == RECALL) && !walk_end;
	assign lrn_rd_en_o = (state_q == LEARN) && !walk_end && !need_wr;
	assign rcl_axon_o  = axn_rd;
	assign lrn_axon_o  = axn_rd;
	assign save_o      = (state_q == SAVE);

	assign mem.rd_en   = rcl_rd_en_o || lrn_rd_en_o;
	assign mem.rd_addr = {nrn_q, axn_rd};
	assign mem.wr_en   = need_wr;
	assign mem.wr_addr = {nrn_q, axn_wr};
	// plus one, stuck at the ceiling
	assign mem.wr_data = (mem.rd_data == WEIGHT_MAX) ? WEIGHT_MAX :
		weight_t'(mem.rd_data + weight_t'(1));

	assign push_o    = (state_q == FIRE) && fire_now && not_full_i;
	assign push_id_o = nrn_q;

	// ------------------------------------------------------------------
	// sequencer
	// ------------------------------------------------------------------

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q    <= IDLE;
			nrn_q      <= '0;
			axn_q      <= '0;
			fire_q     <= '0;
			learn_q    <= 1'b0;
			rd_vld_q   <= 1'b0;
			push_cnt_q <= '0;
			busy_o     <= 1'b0;
			done_o     <= 1'b0;
			for (int n = 0; n < NUM_NEURONS; n++) begin
				pot_q[n] <= '0;
			end
		end else begin
			rd_vld_q <= mem.rd_en;
			done_o   <= 1'b0;
			if (push_o) begin
				push_cnt_q <= push_cnt_q + 1'b1;
			end
			case (state_q)
				IDLE: begin
					if (start_i) begin
						state_q    <= RECALL;
						busy_o     <= 1'b1;
						learn_q    <= learn_i;
						fire_q     <= '0;
						push_cnt_q <= '0;
						nrn_q      <= '0;
						axn_q      <= '0;
					end
				end
				RECALL: begin
					// integrate weight of an active axon
					if (rd_vld_q && rcl_spike_i) begin
						pot_q[nrn_q] <= sat_add(pot_q[nrn_q], potential_t'(mem.rd_data));
					end
					if (walk_end) begin
						axn_q <= '0;
						nrn_q <= nrn_q + 1'b1;
						if (last_nrn) begin
							state_q <= FIRE;
						end
					end else begin
						axn_q <= axn_q + 1'b1;
					end
				end
				FIRE: begin
					// one neuron per cycle unless stalled
					if (fire_go) begin
						pot_q[nrn_q]  <= fire_now ? '0 : leak_pot;
						fire_q[nrn_q] <= fire_now;
						nrn_q         <= nrn_q + 1'b1;
						if (last_nrn) begin
							state_q <= SAVE;
						end
					end
				end
				SAVE: begin
					state_q <= learn_q ? LEARN : DRAIN;
				end
				LEARN: begin
					// write cycle holds the walk in place
					if (!need_wr) begin
						if (walk_end) begin
							axn_q <= '0;
							nrn_q <= nrn_q + 1'b1;
							if (last_nrn) begin
								state_q <= DRAIN;
							end
						end else begin
							axn_q <= axn_q + 1'b1;
						end
					end
				end
				DRAIN: begin
					// close once every fired id has been queued
					if (push_cnt_q == ($bits(push_cnt_q))'($countones(fire_q))) begin
						state_q <= IDLE;
						busy_o  <= 1'b0;
						done_o  <= 1'b1;
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

endmodule

// File: src/synapse_mem.sv
`timescale 1ns/10ps

module synapse_mem import spike_core_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_n_i,
	// host side weight load
	input  logic      cfg_we_i,
	input  syn_addr_t cfg_addr_i,
	input  weight_t   cfg_data_i,
	// controller side
	syn_mem_if.mem    mem
);

	// weight per neuron/axon pair
	weight_t weight_q [NUM_SYN];

	// ------------------------------------------------------------------
	// write ports
	// ------------------------------------------------------------------

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_SYN; i++) begin
				weight_q[i] <= '0;
			end
		end else begin
			// learning update has priority
			if (mem.wr_en) begin
				weight_q[mem.wr_addr] <= mem.wr_data;
			end else if (cfg_we_i) begin
				// config load only when the controller is quiet
				weight_q[cfg_addr_i] <= cfg_data_i;
			end
		end
	end

	// ------------------------------------------------------------------
	// read port
	// ------------------------------------------------------------------

	// one cycle latency, holds value between reads
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mem.rd_data <= '0;
		end else if (mem.rd_en) begin
			mem.rd_data <= weight_q[mem.rd_addr];
		end
	end

endmodule

// File: src/in_spike_buf.sv
`timescale 1ns/10ps

module in_spike_buf import spike_core_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_n_i,
	// step start, spikes sampled here
	input  logic       start_i,
	input  spike_vec_t spike_in_i,
	// recall read port
	input  logic       rcl_rd_en_i,
	input  axon_addr_t rcl_axon_i,
	// recall to learning copy
	input  logic       save_i,
	// learning read port
	input  logic       lrn_rd_en_i,
	input  axon_addr_t lrn_axon_i,
	output logic       rcl_spike_o,
	output logic       lrn_spike_o
);

	// spike copy used while integrating
	spike_vec_t rcl_buf_q;
	// spike copy used while learning
	spike_vec_t lrn_buf_q;

	// ------------------------------------------------------------------
	// buffer registers
	// ------------------------------------------------------------------

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rcl_buf_q <= '0;
			lrn_buf_q <= '0;
		end else begin
			// new step overwrites the recall copy
			if (start_i) begin
				rcl_buf_q <= spike_in_i;
			end
			// freeze recall spikes for the learning walk
			if (save_i) begin
				lrn_buf_q <= rcl_buf_q;
			end
		end
	end

	// ------------------------------------------------------------------
	// registered single bit reads
	// ------------------------------------------------------------------

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rcl_spike_o <= 1'b0;
			lrn_spike_o <= 1'b0;
		end else begin
			// lines up with the weight read
			if (rcl_rd_en_i) begin
				rcl_spike_o <= rcl_buf_q[rcl_axon_i];
			end
			if (lrn_rd_en_i) begin
				lrn_spike_o <= lrn_buf_q[lrn_axon_i];
			end
		end
	end

endmodule

// File: src/syn_mem_if.sv
`timescale 1ns/10ps

// controller to synapse memory link
interface syn_mem_if import spike_core_pkg::*; ();

	// read request, data follows one cycle later
	logic      rd_en;
	syn_addr_t rd_addr;
	weight_t   rd_data;

	// learning write back
	logic      wr_en;
	syn_addr_t wr_addr;
	weight_t   wr_data;

	modport ctrl (
		output rd_en, rd_addr, wr_en, wr_addr, wr_data,
		input  rd_data
	);

	modport mem (
		input  rd_en, rd_addr, wr_en, wr_addr, wr_data,
		output rd_data
	);

endinterface

// File: src/spike_core_pkg.sv
package spike_core_pkg;

	// ------------------------------------------------------------------
	// core sizes
	// ------------------------------------------------------------------

	// input axons per core
	localparam int NUM_AXONS   = 16;
	// neurons per core
	localparam int NUM_NEURONS = 4;
	// address widths
	localparam int AXON_W      = 4;
	localparam int NEURON_W    = 2;
	// one weight per neuron/axon pair
	localparam int NUM_SYN     = NUM_NEURONS * NUM_AXONS;

	// output queue and credit pool
	localparam int OUT_DEPTH   = 4;
	localparam int OUT_CREDITS = 2;

	// ------------------------------------------------------------------
	// vector types
	// ------------------------------------------------------------------

	typedef logic [AXON_W-1:0]          axon_addr_t;
	typedef logic [NEURON_W-1:0]        neuron_id_t;
	// neuron id in the upper bits, axon in the lower bits
	typedef logic [NEURON_W+AXON_W-1:0] syn_addr_t;
	typedef logic [NUM_AXONS-1:0]       spike_vec_t;
	typedef logic [NUM_NEURONS-1:0]     fire_vec_t;
	typedef logic signed [7:0]          weight_t;
	typedef logic signed [11:0]         potential_t;

	// ------------------------------------------------------------------
	// neuron model
	// ------------------------------------------------------------------

	// learning saturates here
	localparam weight_t    WEIGHT_MAX = 8'sd127;
	// clamp limits of the membrane potential
	localparam potential_t POT_MAX    = 12'sh7ff;
	localparam potential_t POT_MIN    = 12'sh800;
	// removed once per step, after integration
	localparam potential_t LEAK       = 12'sd2;
	// fire at or above this level
	localparam potential_t THRESHOLD  = 12'sd40;

	// controller phases of one time step
	typedef enum logic [2:0] {
		IDLE,
		RECALL,
		FIRE,
		SAVE,
		LEARN,
		DRAIN
	} ctrl_state_t;

endpackage
